// ==== common/isa_pkg.sv ====
package isa_pkg;

  // opcode field positions
  localparam int op6_lsb = 26;
  localparam int op4_lsb = 22;
  localparam int op2_lsb = 20;
  localparam int op5_lsb = 15;

  // register and immediate field positions
  localparam int rd_lsb = 0;
  localparam int rj_lsb = 5;
  localparam int rk_lsb = 10;
  localparam int imm12_lsb = 10;
  localparam int imm16_lsb = 10;
  localparam int imm20_lsb = 5;
  localparam int imm26_hi_lsb = 0;

  localparam logic [4:0] reg_link = 5'd1;

  // bits 31..26
  localparam logic [5:0] op6_special = 6'h00;
  localparam logic [5:0] op6_lu12i = 6'h05;
  localparam logic [5:0] op6_pcaddu12i = 6'h07;
  localparam logic [5:0] op6_mem = 6'h0a;
  localparam logic [5:0] op6_jirl = 6'h13;
  localparam logic [5:0] op6_b = 6'h14;
  localparam logic [5:0] op6_bl = 6'h15;
  localparam logic [5:0] op6_beq = 6'h16;
  localparam logic [5:0] op6_bne = 6'h17;

  // bits 25..22
  localparam logic [3:0] op4_reg = 4'h0;
  localparam logic [3:0] op4_shift_imm = 4'h1;
  localparam logic [3:0] op4_ld_w = 4'h2;
  localparam logic [3:0] op4_st_w = 4'h6;
  localparam logic [3:0] op4_slti = 4'h8;
  localparam logic [3:0] op4_sltui = 4'h9;
  localparam logic [3:0] op4_addi = 4'ha;
  localparam logic [3:0] op4_andi = 4'hd;
  localparam logic [3:0] op4_ori = 4'he;
  localparam logic [3:0] op4_xori = 4'hf;

  // bits 21..20
  localparam logic [1:0] op2_shift_imm = 2'h0;
  localparam logic [1:0] op2_3r = 2'h1;
  localparam logic [1:0] op2_div = 2'h2;

  // bits 19..15, three-register group
  localparam logic [4:0] op5_add = 5'h00;
  localparam logic [4:0] op5_sub = 5'h02;
  localparam logic [4:0] op5_slt = 5'h04;
  localparam logic [4:0] op5_sltu = 5'h05;
  localparam logic [4:0] op5_nor = 5'h08;
  localparam logic [4:0] op5_and = 5'h09;
  localparam logic [4:0] op5_or = 5'h0a;
  localparam logic [4:0] op5_xor = 5'h0b;
  localparam logic [4:0] op5_sll = 5'h0e;
  localparam logic [4:0] op5_srl = 5'h0f;
  localparam logic [4:0] op5_sra = 5'h10;
  localparam logic [4:0] op5_mul = 5'h18;
  localparam logic [4:0] op5_mulh = 5'h19;
  localparam logic [4:0] op5_mulhu = 5'h1a;

  // bits 19..15, divide group
  localparam logic [4:0] op5_div = 5'h00;
  localparam logic [4:0] op5_mod = 5'h01;
  localparam logic [4:0] op5_divu = 5'h02;
  localparam logic [4:0] op5_modu = 5'h03;

  // bits 19..15, immediate shifts
  localparam logic [4:0] op5_slli = 5'h01;
  localparam logic [4:0] op5_srli = 5'h09;
  localparam logic [4:0] op5_srai = 5'h11;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_nor, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_lui,
    alu_mul, alu_mulh, alu_mulhu, alu_div, alu_divu, alu_mod, alu_modu
  } alu_op_e;

  typedef enum logic [2:0] {
    br_none, br_beq, br_bne, br_b, br_bl, br_jirl
  } br_kind_e;

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;
  import isa_pkg::*;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fs2ds_t;

  typedef struct packed {
    logic        we;
    logic [4:0]  addr;
    logic [31:0] data;
  } wb_rf_t;

  // is_load only meaningful on the execute source
  typedef struct packed {
    logic        we;
    logic [4:0]  dest;
    logic        is_load;
    logic [31:0] value;
  } fwd_t;

  typedef struct packed {
    logic        taken;
    logic [31:0] target;
  } br_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] alu_src1;
    logic [31:0] alu_src2;
    alu_op_e     alu_op;
    logic [31:0] store_data;
    logic        res_from_mem;
    logic        res_from_mul;
    logic        gr_we;
    logic        mem_we;
    logic [4:0]  dest;
  } ds2es_t;

  // unused source addresses are zero
  typedef struct packed {
    alu_op_e     alu_op;
    br_kind_e    br_kind;
    logic        src1_is_pc;
    logic        src2_is_imm;
    logic [31:0] imm;
    logic [31:0] br_offs;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [4:0]  dest;
    logic        gr_we;
    logic        mem_we;
    logic        res_from_mem;
    logic        res_from_mul;
    logic        is_load;
  } decode_t;

endpackage

// ==== logic/regfile.sv ====
module regfile (
  input  logic        clk,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  input  logic        we,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2
);

  logic [31:0] rf [32];

  // r0 is never written
  always_ff @(posedge clk) begin
    if (we && waddr != 5'd0) begin
      rf[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

// ==== decode/inst_decoder.sv ====
module inst_decoder
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic [31:0] inst,
  output decode_t     dec
);

  logic [5:0]  op6;
  logic [3:0]  op4;
  logic [1:0]  op2;
  logic [4:0]  op5;
  logic [4:0]  rd;
  logic [4:0]  rj;
  logic [4:0]  rk;
  logic [11:0] i12;
  logic [15:0] i16;
  logic [19:0] i20;
  logic [25:0] i26;

  logic        known;
  alu_op_e     op;
  br_kind_e    kind;
  logic        use_rj;
  logic        use_rk;
  logic        use_rd;
  logic        writes;
  logic        src1_pc;
  logic        src2_imm;
  logic        load;
  logic        store;
  logic        mul;
  logic        long_offs;
  logic [31:0] imm_v;

  assign op6 = inst[op6_lsb +: 6];
  assign op4 = inst[op4_lsb +: 4];
  assign op2 = inst[op2_lsb +: 2];
  assign op5 = inst[op5_lsb +: 5];
  assign rd  = inst[rd_lsb +: 5];
  assign rj  = inst[rj_lsb +: 5];
  assign rk  = inst[rk_lsb +: 5];
  assign i12 = inst[imm12_lsb +: 12];
  assign i16 = inst[imm16_lsb +: 16];
  assign i20 = inst[imm20_lsb +: 20];
  // 26-bit offset is split, high part sits in the low bits
  assign i26 = {inst[imm26_hi_lsb +: 10], i16};

  always_comb begin
    known     = 1'b1;
    op        = alu_add;
    kind      = br_none;
    use_rj    = 1'b1;
    use_rk    = 1'b0;
    use_rd    = 1'b0;
    writes    = 1'b1;
    src1_pc   = 1'b0;
    src2_imm  = 1'b1;
    load      = 1'b0;
    store     = 1'b0;
    mul       = 1'b0;
    long_offs = 1'b0;
    imm_v     = {{20{i12[11]}}, i12};
    case (op6)
      op6_special: begin
        if (op4 == op4_reg && op2 == op2_3r) begin
          use_rk   = 1'b1;
          src2_imm = 1'b0;
          case (op5)
            op5_add:   op = alu_add;
            op5_sub:   op = alu_sub;
            op5_slt:   op = alu_slt;
            op5_sltu:  op = alu_sltu;
            op5_nor:   op = alu_nor;
            op5_and:   op = alu_and;
            op5_or:    op = alu_or;
            op5_xor:   op = alu_xor;
            op5_sll:   op = alu_sll;
            op5_srl:   op = alu_srl;
            op5_sra:   op = alu_sra;
            op5_mul:   op = alu_mul;
            op5_mulh:  op = alu_mulh;
            op5_mulhu: op = alu_mulhu;
            default:   known = 1'b0;
          endcase
          mul = (op5 == op5_mul) || (op5 == op5_mulh) || (op5 == op5_mulhu);
        end else if (op4 == op4_reg && op2 == op2_div) begin
          use_rk   = 1'b1;
          src2_imm = 1'b0;
          case (op5)
            op5_div:  op = alu_div;
            op5_mod:  op = alu_mod;
            op5_divu: op = alu_divu;
            op5_modu: op = alu_modu;
            default:  known = 1'b0;
          endcase
        end else if (op4 == op4_shift_imm && op2 == op2_shift_imm) begin
          case (op5)
            op5_slli: op = alu_sll;
            op5_srli: op = alu_srl;
            op5_srai: op = alu_sra;
            default:  known = 1'b0;
          endcase
        end else begin
          case (op4)
            op4_slti:  op = alu_slt;
            op4_sltui: op = alu_sltu;
            op4_addi:  op = alu_add;
            op4_andi:  op = alu_and;
            op4_ori:   op = alu_or;
            op4_xori:  op = alu_xor;
            default:   known = 1'b0;
          endcase
          // logic immediates are zero-extended
          if (op4 == op4_andi || op4 == op4_ori || op4 == op4_xori) begin
            imm_v = {20'b0, i12};
          end
        end
      end
      op6_lu12i: begin
        known  = !op4[3];
        op     = alu_lui;
        use_rj = 1'b0;
        imm_v  = {i20, 12'b0};
      end
      op6_pcaddu12i: begin
        known   = !op4[3];
        use_rj  = 1'b0;
        src1_pc = 1'b1;
        imm_v   = {i20, 12'b0};
      end
      op6_mem: begin
        case (op4)
          op4_ld_w: load = 1'b1;
          op4_st_w: begin
            store  = 1'b1;
            writes = 1'b0;
            use_rd = 1'b1;
          end
          default: known = 1'b0;
        endcase
      end
      op6_jirl: begin
        kind    = br_jirl;
        src1_pc = 1'b1;
        imm_v   = 32'd4;
      end
      op6_b: begin
        kind      = br_b;
        use_rj    = 1'b0;
        writes    = 1'b0;
        long_offs = 1'b1;
      end
      op6_bl: begin
        kind      = br_bl;
        use_rj    = 1'b0;
        src1_pc   = 1'b1;
        long_offs = 1'b1;
        imm_v     = 32'd4;
      end
      op6_beq, op6_bne: begin
        kind     = (op6 == op6_beq) ? br_beq : br_bne;
        writes   = 1'b0;
        use_rd   = 1'b1;
        src2_imm = 1'b0;
      end
      default: known = 1'b0;
    endcase
  end

  // unknown encodings collapse to a nop
  always_comb begin
    dec = '0;
    dec.alu_op = alu_add;
    dec.br_kind = br_none;
    if (known) begin
      dec.alu_op       = op;
      dec.br_kind      = kind;
      dec.src1_is_pc   = src1_pc;
      dec.src2_is_imm  = src2_imm;
      dec.imm          = imm_v;
      dec.br_offs      = long_offs ? {{4{i26[25]}}, i26, 2'b0} : {{14{i16[15]}}, i16, 2'b0};
      dec.rs1_addr     = use_rj ? rj : 5'd0;
      dec.rs2_addr     = use_rd ? rd : (use_rk ? rk : 5'd0);
      dec.gr_we        = writes;
      dec.dest         = !writes ? 5'd0 : ((kind == br_bl) ? reg_link : rd);
      dec.mem_we       = store;
      dec.is_load      = load;
      dec.res_from_mem = load;
      dec.res_from_mul = mul;
    end
  end

endmodule

// ==== decode/operand_fetch.sv ====
module operand_fetch
  import pipe_pkg::*;
(
  input  logic        clk,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  fwd_t        exe_fwd,
  input  fwd_t        mem_fwd,
  input  wb_rf_t      wb_rf,
  output logic [31:0] rs1_value,
  output logic [31:0] rs2_value,
  output logic        load_use
);

  logic [31:0] rf_rdata1;
  logic [31:0] rf_rdata2;
  logic        hit1;
  logic        hit2;

  // youngest result wins, r0 is never forwarded
  function automatic logic [31:0] pick(
    input logic [4:0]  addr,
    input fwd_t        exe,
    input fwd_t        mem,
    input wb_rf_t      wb,
    input logic [31:0] rf_data
  );
    logic [31:0] val;
    val = rf_data;
    if (addr != 5'd0) begin
      if (exe.we && exe.dest == addr) begin
        val = exe.value;
      end else if (mem.we && mem.dest == addr) begin
        val = mem.value;
      end else if (wb.we && wb.addr == addr) begin
        val = wb.data;
      end
    end
    return val;
  endfunction

  regfile u_regfile (
    .clk    (clk),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .we     (wb_rf.we),
    .waddr  (wb_rf.addr),
    .wdata  (wb_rf.data),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  assign rs1_value = pick(rs1_addr, exe_fwd, mem_fwd, wb_rf, rf_rdata1);
  assign rs2_value = pick(rs2_addr, exe_fwd, mem_fwd, wb_rf, rf_rdata2);

  // load data is not ready until memory
  assign hit1 = (rs1_addr != 5'd0) && (exe_fwd.dest == rs1_addr);
  assign hit2 = (rs2_addr != 5'd0) && (exe_fwd.dest == rs2_addr);
  assign load_use = exe_fwd.we && exe_fwd.is_load && (hit1 || hit2);

endmodule

// ==== decode/issue_control.sv ====
module issue_control
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        fs2ds_valid,
  input  fs2ds_t      fs2ds,
  input  logic        es_allowin,
  input  decode_t     dec,
  input  logic [31:0] rs1_value,
  input  logic [31:0] rs2_value,
  input  logic        load_use,
  output logic [31:0] inst,
  output logic        ds_allowin,
  output logic        ds2es_valid,
  output ds2es_t      ds2es,
  output br_t         br
);

  logic        ds_valid;
  logic [31:0] ds_pc;
  logic        stall;
  logic        cond_met;
  logic        br_taken;

  assign stall       = ds_valid && load_use;
  assign ds_allowin  = !ds_valid || (!stall && es_allowin);
  assign ds2es_valid = ds_valid && !stall;

  // a taken branch also drops whatever fetch hands over at that edge
  always_ff @(posedge clk) begin
    if (reset || br_taken) begin
      ds_valid <= 1'b0;
    end else if (ds_allowin) begin
      ds_valid <= fs2ds_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (fs2ds_valid && ds_allowin) begin
      ds_pc <= fs2ds.pc;
      inst  <= fs2ds.inst;
    end
  end

  always_comb begin
    case (dec.br_kind)
      br_beq:                cond_met = (rs1_value == rs2_value);
      br_bne:                cond_met = (rs1_value != rs2_value);
      br_b, br_bl, br_jirl:  cond_met = 1'b1;
      default:               cond_met = 1'b0;
    endcase
  end

  // only on the edge the branch moves into execute
  assign br_taken = cond_met && ds2es_valid && es_allowin;

  always_comb begin
    br.taken  = br_taken;
    br.target = (dec.br_kind == br_jirl) ? rs1_value + dec.br_offs : ds_pc + dec.br_offs;
  end

  always_comb begin
    ds2es.pc           = ds_pc;
    ds2es.alu_src1     = dec.src1_is_pc ? ds_pc : rs1_value;
    ds2es.alu_src2     = dec.src2_is_imm ? dec.imm : rs2_value;
    ds2es.alu_op       = dec.alu_op;
    ds2es.store_data   = rs2_value;
    ds2es.res_from_mem = dec.res_from_mem;
    ds2es.res_from_mul = dec.res_from_mul;
    ds2es.gr_we        = dec.gr_we;
    ds2es.mem_we       = dec.mem_we;
    ds2es.dest         = dec.dest;
  end

endmodule

// ==== decode/decode_stage.sv ====
module decode_stage
  import pipe_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   fs2ds_valid,
  input  fs2ds_t fs2ds,
  input  logic   es_allowin,
  input  fwd_t   exe_fwd,
  input  fwd_t   mem_fwd,
  input  wb_rf_t wb_rf,
  output logic   ds_allowin,
  output logic   ds2es_valid,
  output ds2es_t ds2es,
  output br_t    br
);

  logic [31:0] inst;
  decode_t     dec;
  logic [31:0] rs1_value;
  logic [31:0] rs2_value;
  logic        load_use;

  inst_decoder u_inst_decoder (
    .inst (inst),
    .dec  (dec)
  );

  operand_fetch u_operand_fetch (
    .clk       (clk),
    .rs1_addr  (dec.rs1_addr),
    .rs2_addr  (dec.rs2_addr),
    .exe_fwd   (exe_fwd),
    .mem_fwd   (mem_fwd),
    .wb_rf     (wb_rf),
    .rs1_value (rs1_value),
    .rs2_value (rs2_value),
    .load_use  (load_use)
  );

  issue_control u_issue_control (
    .clk         (clk),
    .reset       (reset),
    .fs2ds_valid (fs2ds_valid),
    .fs2ds       (fs2ds),
    .es_allowin  (es_allowin),
    .dec         (dec),
    .rs1_value   (rs1_value),
    .rs2_value   (rs2_value),
    .load_use    (load_use),
    .inst        (inst),
    .ds_allowin  (ds_allowin),
    .ds2es_valid (ds2es_valid),
    .ds2es       (ds2es),
    .br          (br)
  );

endmodule

// ==== test/tb_decode_stage.sv ====
module tb_decode_stage
  import isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int preload_len = 50;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;
  localparam logic [5:0] pc_src = 6'h20;
  localparam logic [5:0] imm_src = 6'h20;
  // res_from_mem, res_from_mul, gr_we, mem_we
  localparam logic [3:0] f_none = 4'b0000;
  localparam logic [3:0] f_wr = 4'b0010;
  localparam logic [3:0] f_mul = 4'b0110;
  localparam logic [3:0] f_ld = 4'b1010;
  localparam logic [3:0] f_st = 4'b0001;

  // s1 and s2 carry a select bit above the register address
  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic        allow;
    fwd_t        exe;
    fwd_t        mem;
    wb_rf_t      wb;
    logic        ex_valid;
    alu_op_e     op;
    logic        ops;
    logic [5:0]  s1;
    logic [5:0]  s2;
    logic [31:0] imm;
    logic [4:0]  dest;
    logic [3:0]  flags;
    br_kind_e    bk;
    logic [31:0] offs;
  } vec_t;

  logic   clk;
  logic   reset;
  logic   fs2ds_valid;
  fs2ds_t fs2ds;
  logic   es_allowin;
  fwd_t   exe_fwd;
  fwd_t   mem_fwd;
  wb_rf_t wb_rf;
  logic   ds_allowin;
  logic   ds2es_valid;
  ds2es_t ds2es;
  br_t    br;

  logic [31:0] model [32];
  logic [31:0] lfsr = 32'd46;
  vec_t        table_q [$];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          limit = preload_len;

  decode_stage dut (
    .clk         (clk),
    .reset       (reset),
    .fs2ds_valid (fs2ds_valid),
    .fs2ds       (fs2ds),
    .es_allowin  (es_allowin),
    .exe_fwd     (exe_fwd),
    .mem_fwd     (mem_fwd),
    .wb_rf       (wb_rf),
    .ds_allowin  (ds_allowin),
    .ds2es_valid (ds2es_valid),
    .ds2es       (ds2es),
    .br          (br)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    while (cycles <= limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

  function automatic logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ lfsr_taps;
    return b;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    for (int i = 0; i < 32; i++) w = {w[30:0], next_bit()};
    return w;
  endfunction

  // instruction encoders
  function automatic logic [31:0] r3(input logic [4:0] op5, rd, rj, rk);
    return {op6_special, op4_reg, op2_3r, op5, rk, rj, rd};
  endfunction

  function automatic logic [31:0] dv(input logic [4:0] op5, rd, rj, rk);
    return {op6_special, op4_reg, op2_div, op5, rk, rj, rd};
  endfunction

  function automatic logic [31:0] shi(input logic [4:0] op5, rd, rj, ui5);
    return {op6_special, op4_shift_imm, op2_shift_imm, op5, ui5, rj, rd};
  endfunction

  function automatic logic [31:0] ri(input logic [5:0] op6, input logic [3:0] op4,
                                     input logic [4:0] rd, rj, input logic [11:0] i12);
    return {op6, op4, i12, rj, rd};
  endfunction

  function automatic logic [31:0] upi(input logic [5:0] op6, input logic [4:0] rd,
                                      input logic [19:0] i20);
    return {op6, 1'b0, i20, rd};
  endfunction

  function automatic logic [31:0] bi(input logic [5:0] op6, input logic [4:0] rd, rj,
                                     input logic [15:0] i16);
    return {op6, i16, rj, rd};
  endfunction

  function automatic logic [31:0] ji(input logic [5:0] op6, input logic [25:0] i26);
    return {op6, i26[15:0], i26[25:16]};
  endfunction

  function automatic fwd_t fwd_src(input logic [4:0] dest, input logic ld,
                                   input logic [31:0] value);
    return {1'b1, dest, ld, value};
  endfunction

  function automatic wb_rf_t wb_src(input logic [4:0] addr, input logic [31:0] data);
    return {1'b1, addr, data};
  endfunction

  function automatic vec_t entry(input logic [31:0] inst, input alu_op_e op,
                                 input logic [5:0] s1, s2, input logic [31:0] imm,
                                 input logic [4:0] dest, input logic [3:0] flags);
    vec_t v;
    v = '0;
    v.inst = inst;
    v.allow = 1'b1;
    v.ex_valid = 1'b1;
    v.op = op;
    v.ops = 1'b1;
    v.s1 = s1;
    v.s2 = s2;
    v.imm = imm;
    v.dest = dest;
    v.flags = flags;
    v.bk = br_none;
    return v;
  endfunction

  // execute first, then memory, then write-back, r0 never
  function automatic logic [31:0] operand(input logic [4:0] addr);
    if (addr == 5'd0) return 32'd0;
    if (exe_fwd.we && exe_fwd.dest == addr) return exe_fwd.value;
    if (mem_fwd.we && mem_fwd.dest == addr) return mem_fwd.value;
    if (wb_rf.we && wb_rf.addr == addr) return wb_rf.data;
    return model[addr];
  endfunction

  function automatic logic branch_taken(input vec_t v);
    logic [31:0] a;
    logic [31:0] b;
    a = operand(v.s1[4:0]);
    b = operand(v.s2[4:0]);
    case (v.bk)
      br_beq: return a == b;
      br_bne: return a != b;
      br_b, br_bl, br_jirl: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic add_vec(input vec_t v);
    v.pc = 32'h1c00_0100 + (table_q.size() << 4);
    table_q.push_back(v);
  endtask

  task automatic check_out(input vec_t v, input logic valid, input logic go);
    logic [31:0] a;
    logic [31:0] b;
    logic        taken;
    a = operand(v.s1[4:0]);
    b = operand(v.s2[4:0]);
    taken = go && branch_taken(v);
    compare("ds2es_valid", ds2es_valid, valid);
    compare("ds_allowin", ds_allowin, go);
    compare("br.taken", br.taken, taken);
    if (taken) begin
      compare("br.target", br.target, (v.bk == br_jirl) ? a + v.offs : v.pc + v.offs);
    end
    if (valid) begin
      compare("pc", ds2es.pc, v.pc);
      compare("alu_op", ds2es.alu_op, v.op);
      compare("flags", {ds2es.res_from_mem, ds2es.res_from_mul, ds2es.gr_we, ds2es.mem_we},
              v.flags);
      if (v.ops) begin
        compare("alu_src1", ds2es.alu_src1, v.s1[5] ? v.pc : a);
        compare("alu_src2", ds2es.alu_src2, v.s2[5] ? v.imm : b);
      end
      if (v.flags[1]) compare("dest", ds2es.dest, v.dest);
      if (v.flags[0]) compare("store_data", ds2es.store_data, b);
    end
  endtask

  // fetch keeps going behind a taken branch
  task automatic fetch_behind(input vec_t v);
    if (branch_taken(v)) begin
      fs2ds_valid = 1'b1;
      fs2ds = {v.pc + 32'd4, r3(op5_add, 3, 4, 5)};
    end
  endtask

  task automatic run_vec(input vec_t v);
    logic   acc;
    logic   go;
    ds2es_t held;
    fs2ds_valid = 1'b1;
    fs2ds = {v.pc, v.inst};
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = ds_allowin;
      @(posedge clk);
      #2;
    end
    fs2ds_valid = 1'b0;
    es_allowin = v.allow;
    exe_fwd = v.exe;
    mem_fwd = v.mem;
    wb_rf = v.wb;
    if (v.wb.we && v.wb.addr != 5'd0) model[v.wb.addr] = v.wb.data;
    go = v.allow && v.ex_valid;
    if (go) begin
      fetch_behind(v);
    end else begin
      // fetch already offers the next instruction while the stage is held
      fs2ds_valid = 1'b1;
      fs2ds = {v.pc + 32'd4, r3(op5_sub, 6, 7, 8)};
    end
    @(negedge clk);
    check_out(v, v.ex_valid, go);
    if (!go) begin
      held = ds2es;
      @(posedge clk);
      #2;
      @(negedge clk);
      checks++;
      assert (ds2es === held) else begin
        errors++;
        $display("FAILED ds2es: got %h expected %h", ds2es, held);
      end
      compare("ds2es_valid", ds2es_valid, v.ex_valid);
      compare("br.taken", br.taken, 1'b0);
      @(posedge clk);
      #2;
      fs2ds_valid = 1'b0;
      es_allowin = 1'b1;
      exe_fwd = '0;
      fetch_behind(v);
      @(negedge clk);
      check_out(v, 1'b1, 1'b1);
    end
    @(posedge clk);
    #2;
    fs2ds_valid = 1'b0;
    exe_fwd = '0;
    mem_fwd = '0;
    wb_rf = '0;
    @(negedge clk);
    compare("ds2es_valid", ds2es_valid, 1'b0);
    @(posedge clk);
    #2;
  endtask

  task automatic build_table();
    vec_t v;
    add_vec(entry(r3(op5_add, 3, 4, 5), alu_add, 4, 5, 0, 3, f_wr));
    add_vec(entry(r3(op5_sub, 6, 7, 8), alu_sub, 7, 8, 0, 6, f_wr));
    add_vec(entry(r3(op5_sltu, 9, 10, 11), alu_sltu, 10, 11, 0, 9, f_wr));
    add_vec(entry(r3(op5_nor, 12, 13, 14), alu_nor, 13, 14, 0, 12, f_wr));
    add_vec(entry(r3(op5_xor, 15, 16, 17), alu_xor, 16, 17, 0, 15, f_wr));
    add_vec(entry(r3(op5_sra, 18, 19, 20), alu_sra, 19, 20, 0, 18, f_wr));
    add_vec(entry(r3(op5_mul, 21, 22, 23), alu_mul, 22, 23, 0, 21, f_mul));
    add_vec(entry(r3(op5_mulhu, 24, 25, 26), alu_mulhu, 25, 26, 0, 24, f_mul));
    add_vec(entry(dv(op5_divu, 27, 28, 29), alu_divu, 28, 29, 0, 27, f_wr));
    add_vec(entry(dv(op5_mod, 30, 31, 1), alu_mod, 31, 1, 0, 30, f_wr));
    add_vec(entry(ri(op6_special, op4_addi, 2, 3, 12'hffb), alu_add, 3, imm_src,
                  32'hffff_fffb, 2, f_wr));
    add_vec(entry(ri(op6_special, op4_slti, 4, 5, 12'h800), alu_slt, 5, imm_src,
                  32'hffff_f800, 4, f_wr));
    add_vec(entry(ri(op6_special, op4_sltui, 6, 7, 12'h7ff), alu_sltu, 7, imm_src,
                  32'h0000_07ff, 6, f_wr));
    add_vec(entry(ri(op6_special, op4_andi, 8, 9, 12'hf0f), alu_and, 9, imm_src,
                  32'h0000_0f0f, 8, f_wr));
    add_vec(entry(ri(op6_special, op4_ori, 10, 11, 12'h801), alu_or, 11, imm_src,
                  32'h0000_0801, 10, f_wr));
    add_vec(entry(ri(op6_special, op4_xori, 12, 13, 12'hfff), alu_xor, 13, imm_src,
                  32'h0000_0fff, 12, f_wr));
    add_vec(entry(shi(op5_slli, 14, 15, 7), alu_sll, 15, imm_src, 32'h027, 14, f_wr));
    add_vec(entry(shi(op5_srai, 16, 17, 3), alu_sra, 17, imm_src, 32'h223, 16, f_wr));
    add_vec(entry(upi(op6_lu12i, 18, 20'habcde), alu_lui, 0, imm_src, 32'habcd_e000, 18, f_wr));
    add_vec(entry(upi(op6_pcaddu12i, 19, 20'h00012), alu_add, pc_src, imm_src,
                  32'h0001_2000, 19, f_wr));
    add_vec(entry(ri(op6_mem, op4_ld_w, 20, 21, 12'hffc), alu_add, 21, imm_src,
                  32'hffff_fffc, 20, f_ld));
    add_vec(entry(ri(op6_mem, op4_st_w, 22, 23, 12'h008), alu_add, 23, imm_src | 22,
                  32'h8, 0, f_st));
    // forwarding priority
    v = entry(r3(op5_add, 24, 25, 26), alu_add, 25, 26, 0, 24, f_wr);
    v.exe = fwd_src(25, 1'b0, 32'h1111_1111);
    v.mem = fwd_src(25, 1'b0, 32'h2222_2222);
    v.wb = wb_src(25, 32'h3333_3333);
    add_vec(v);
    v.exe = fwd_src(25, 1'b0, 32'h1212_1212);
    v.mem = fwd_src(26, 1'b0, 32'h2323_2323);
    v.wb = wb_src(26, 32'h3434_3434);
    add_vec(v);
    v.exe = '0;
    v.mem = '0;
    v.wb = wb_src(25, 32'h4444_4444);
    add_vec(v);
    v = entry(r3(op5_add, 27, 0, 28), alu_add, 0, 28, 0, 27, f_wr);
    v.exe = fwd_src(0, 1'b0, 32'hdead_beef);
    v.mem = fwd_src(0, 1'b0, 32'hcafe_f00d);
    v.wb = wb_src(0, 32'h0bad_0bad);
    add_vec(v);
    v = entry(r3(op5_add, 29, 28, 30), alu_add, 28, 30, 0, 29, f_wr);
    v.exe = {1'b0, 5'd28, 1'b0, 32'h5a5a_5a5a};
    add_vec(v);
    // load-use
    v = entry(r3(op5_add, 3, 4, 5), alu_add, 4, 5, 0, 3, f_wr);
    v.exe = fwd_src(4, 1'b1, 32'h0);
    v.mem = fwd_src(4, 1'b0, 32'h5555_aaaa);
    v.ex_valid = 1'b0;
    add_vec(v);
    v = entry(ri(op6_mem, op4_st_w, 6, 7, 12'h004), alu_add, 7, imm_src | 6, 32'h4, 0, f_st);
    v.exe = fwd_src(6, 1'b1, 32'h0);
    v.ex_valid = 1'b0;
    add_vec(v);
    v = entry(bi(op6_beq, 9, 8, 16'h0004), alu_add, 8, 9, 0, 0, f_none);
    v.bk = br_beq;
    v.offs = 32'h10;
    v.exe = fwd_src(9, 1'b1, 32'h0);
    v.ex_valid = 1'b0;
    add_vec(v);
    v = entry(r3(op5_add, 10, 11, 12), alu_add, 11, 12, 0, 10, f_wr);
    v.exe = fwd_src(13, 1'b1, 32'h7777_7777);
    add_vec(v);
    v = entry(upi(op6_lu12i, 14, 20'h00001), alu_lui, 0, imm_src, 32'h1000, 14, f_wr);
    v.exe = fwd_src(0, 1'b1, 32'h7777_7777);
    add_vec(v);
    // back-pressure
    v = entry(r3(op5_add, 15, 16, 17), alu_add, 16, 17, 0, 15, f_wr);
    v.allow = 1'b0;
    add_vec(v);
    v = entry(ri(op6_mem, op4_ld_w, 20, 21, 12'h010), alu_add, 21, imm_src, 32'h10, 20, f_ld);
    v.allow = 1'b0;
    v.mem = fwd_src(21, 1'b0, 32'h0000_8000);
    add_vec(v);
    // branches
    v = entry(bi(op6_beq, 5, 5, 16'h0010), alu_add, 5, 5, 0, 0, f_none);
    v.bk = br_beq;
    v.offs = 32'h40;
    add_vec(v);
    v.inst = bi(op6_beq, 6, 5, 16'hfffe);
    v.s2 = 6;
    v.offs = 32'hffff_fff8;
    add_vec(v);
    v = entry(bi(op6_bne, 8, 7, 16'h0020), alu_add, 7, 8, 0, 0, f_none);
    v.bk = br_bne;
    v.offs = 32'h80;
    add_vec(v);
    v.mem = fwd_src(8, 1'b0, model[7]);
    add_vec(v);
    v = entry(ji(op6_b, 26'h0000100), alu_add, 0, 0, 0, 0, f_none);
    v.ops = 1'b0;
    v.bk = br_b;
    v.offs = 32'h400;
    add_vec(v);
    v.allow = 1'b0;
    add_vec(v);
    v = entry(ji(op6_bl, 26'h3ffffff), alu_add, pc_src, imm_src, 32'd4, 1, f_wr);
    v.bk = br_bl;
    v.offs = 32'hffff_fffc;
    add_vec(v);
    v = entry(bi(op6_jirl, 2, 9, 16'h0003), alu_add, pc_src | 9, imm_src, 32'd4, 2, f_wr);
    v.bk = br_jirl;
    v.offs = 32'hc;
    add_vec(v);
    v.allow = 1'b0;
    v.mem = fwd_src(9, 1'b0, 32'h8000_0000);
    add_vec(v);
    // unknown encoding behaves as a nop
    v = entry(32'hffff_ffff, alu_add, 0, 0, 0, 0, f_none);
    v.ops = 1'b0;
    add_vec(v);
  endtask

  initial begin
    reset = 1'b1;
    fs2ds_valid = 1'b0;
    fs2ds = '0;
    es_allowin = 1'b1;
    exe_fwd = '0;
    mem_fwd = '0;
    wb_rf = '0;
    model[0] = 32'd0;
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    compare("ds2es_valid", ds2es_valid, 1'b0);
    compare("br.taken", br.taken, 1'b0);
    compare("ds_allowin", ds_allowin, 1'b1);
    @(posedge clk);
    #2;
    for (int i = 1; i < 32; i++) begin
      model[i] = rand_word();
      wb_rf = {1'b1, 5'(i), model[i]};
      @(posedge clk);
      #2;
    end
    wb_rf = '0;
    build_table();
    limit = preload_len + 40 * table_q.size();
    foreach (table_q[i]) run_vec(table_q[i]);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
common/isa_pkg.sv
common/pipe_pkg.sv
logic/regfile.sv
decode/inst_decoder.sv
decode/operand_fetch.sv
decode/issue_control.sv
decode/decode_stage.sv
test/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - common/isa_pkg.sv
  - common/pipe_pkg.sv
  - logic/regfile.sv
  - decode/inst_decoder.sv
  - decode/operand_fetch.sv
  - decode/issue_control.sv
  - decode/decode_stage.sv
  - target: test
    files:
      - test/tb_decode_stage.sv
